/* source/host_gate_pkg.sv */
package host_gate_pkg;

	// Local bus widths
	localparam int lb_addr_w = 24;
	localparam int lb_data_w = 32;

	// Control word as it travels on the wire
	// Read flag lands on bit 28, address in the low 24 bits
	typedef struct packed {
		logic [2:0]           rsv_hi;
		logic                 rd;
		logic [3:0]           rsv_lo;
		logic [lb_addr_w-1:0] addr;
	} lb_ctl_t;

	// One 8-byte transaction, control word first
	typedef struct packed {
		lb_ctl_t              ctl;
		logic [lb_data_w-1:0] data;
	} lb_frame_s;

	// Same 64 bits seen as decoded fields or as wire bytes
	// bytes[7] is the first byte on the wire
	typedef union packed {
		lb_frame_s       fields;
		logic [7:0][7:0] bytes;
	} lb_frame_u;

	// Identity register
	localparam logic [lb_data_w-1:0] gate_id = 32'h4a58_0001;
	localparam logic [lb_addr_w-1:0] id_addr = 24'h000100;

endpackage

/* source/lb_if.sv */
`timescale 1ns/1ps

// Requester side, one per gateway
interface lb_req_if
	import host_gate_pkg::*;
();
	logic                 req;
	logic                 rd;
	logic [lb_addr_w-1:0] addr;
	logic [lb_data_w-1:0] wdata;
	logic                 gnt;
	// Pulses one cycle after gnt, for reads and writes alike
	logic                 rvalid;
	logic [lb_data_w-1:0] rdata;

	modport master (
		output req, rd, addr, wdata,
		input  gnt, rvalid, rdata
	);

	modport arb (
		input  req, rd, addr, wdata,
		output gnt, rvalid, rdata
	);
endinterface

// Shared bus between arbiter and register bank
interface lb_bus_if
	import host_gate_pkg::*;
();
	logic                 strobe;
	logic                 rd;
	logic [lb_addr_w-1:0] addr;
	logic [lb_data_w-1:0] wdata;
	// Registered, valid the cycle after strobe
	logic [lb_data_w-1:0] rdata;

	modport master (
		output strobe, rd, addr, wdata,
		input  rdata
	);

	modport bank (
		input  strobe, rd, addr, wdata,
		output rdata
	);
endinterface

/* source/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo #(
	parameter int dw = 8,
	parameter int aw = 4
) (
	input  logic          clk,
	input  logic          rst,
	input  logic [dw-1:0] din,
	input  logic          we,
	output logic [dw-1:0] dout,
	input  logic          re,
	output logic          empty,
	output logic          full
);

	logic [dw-1:0] mem [2**aw];
	// Extra top bit tells full from empty
	logic [aw:0]   wp;
	logic [aw:0]   rp;

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wp[aw-1:0]] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wp <= '0;
			rp <= '0;
		end else begin
			if (we) begin
				wp <= wp + 1'b1;
			end
			if (re) begin
				rp <= rp + 1'b1;
			end
		end
	end

	// Head is visible without a read cycle
	assign dout  = mem[rp[aw-1:0]];
	assign empty = (wp == rp);
	assign full  = (wp[aw] != rp[aw]) && (wp[aw-1:0] == rp[aw-1:0]);

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) we |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) re |-> !empty);

endmodule

/* source/host_gate.sv */
`timescale 1ns/1ps

module host_gate
	import host_gate_pkg::*;
#(
	parameter int reply_aw = 5
) (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] rx_din,
	input  logic       rx_stb,
	input  logic       rx_end,
	output logic [7:0] tx_dout,
	output logic       tx_rdy,
	output logic       tx_end,
	input  logic       tx_stb,
	lb_req_if.master   lb
);

	// Receive side
	logic [2:0]        cnt8;
	logic              nonce_done;
	logic              rx_active;
	logic              loopback;
	logic              xfer_last;
	lb_frame_u         rx_frame;
	lb_frame_u         rx_next;
	lb_frame_u         req_frame;
	// Bus side
	logic              req;
	logic              busy;
	lb_ctl_t           ctl_head;
	lb_frame_s         reply_word;
	// Reply assembly
	lb_frame_u         tx_frame;
	lb_frame_u         ret_frame;
	logic              ret_full;
	logic [3:0]        tx_left;
	logic              shift_en;
	logic              tx_idle;
	logic              load_new;
	logic              load_ret;
	logic              park;
	// Reply queue
	logic              reply_we;
	logic [7:0]        reply_byte;
	logic              reply_last;
	logic              reply_empty;
	logic              reply_full;
	logic              tx_done;
	logic              tx_take;
	logic [reply_aw:0] pending;

	// First 8 bytes of a packet go straight back
	assign loopback  = rx_stb & ~nonce_done;
	// Eighth byte of a transaction
	assign xfer_last = rx_stb & nonce_done & (&cnt8);

	always_comb begin
		rx_next.bytes = {rx_frame.bytes[6:0], rx_din};
	end

	always_ff @(posedge clk) begin
		if (rst || rx_end) begin
			cnt8       <= '0;
			nonce_done <= 1'b0;
			rx_active  <= 1'b0;
		end else if (rx_stb) begin
			cnt8      <= cnt8 + 3'd1;
			rx_active <= 1'b1;
			if (&cnt8) begin
				nonce_done <= 1'b1;
			end
		end
	end

	// Latched copy stays put while the next transaction shifts in
	always_ff @(posedge clk) begin
		if (rx_stb) begin
			rx_frame <= rx_next;
		end
		if (xfer_last) begin
			req_frame <= rx_next;
		end
	end

	// Request held until granted, busy until data returns
	always_ff @(posedge clk) begin
		if (rst) begin
			req  <= 1'b0;
			busy <= 1'b0;
		end else begin
			if (xfer_last) begin
				req <= 1'b1;
			end else if (lb.gnt) begin
				req <= 1'b0;
			end
			if (xfer_last) begin
				busy <= 1'b1;
			end else if (lb.rvalid) begin
				busy <= 1'b0;
			end
		end
	end

	assign lb.req   = req;
	assign lb.rd    = req_frame.fields.ctl.rd;
	assign lb.addr  = req_frame.fields.ctl.addr;
	assign lb.wdata = req_frame.fields.data;

	// Control words wait here for their bus return
	byte_fifo #(.dw(32), .aw(2)) ctl_q (
		.clk   (clk),
		.rst   (rst),
		.din   (rx_next.fields.ctl),
		.we    (xfer_last),
		.dout  (ctl_head),
		.re    (lb.rvalid),
		.empty (),
		.full  ()
	);

	assign reply_word = '{ctl: ctl_head, data: lb.rdata};

	// Nonce bytes take the queue first, reply shifting stalls meanwhile
	assign shift_en = (tx_left != 4'd0) & ~loopback;
	// Shifter can take a new frame next cycle
	assign tx_idle  = (tx_left == 4'd0) | ((tx_left == 4'd1) & shift_en);
	assign load_ret = ret_full & tx_idle;
	assign load_new = lb.rvalid & tx_idle & ~ret_full;
	// Return that arrives while the previous reply is still shifting
	assign park     = lb.rvalid & ~load_new;

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_left  <= '0;
			ret_full <= 1'b0;
		end else begin
			if (load_ret || load_new) begin
				tx_left <= 4'd8;
			end else if (shift_en) begin
				tx_left <= tx_left - 4'd1;
			end
			if (park) begin
				ret_full <= 1'b1;
			end else if (load_ret) begin
				ret_full <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (park) begin
			ret_frame.fields <= reply_word;
		end
		if (load_ret) begin
			tx_frame <= ret_frame;
		end else if (load_new) begin
			tx_frame.fields <= reply_word;
		end else if (shift_en) begin
			tx_frame.bytes <= {tx_frame.bytes[6:0], 8'h00};
		end
	end

	assign reply_we   = loopback | shift_en;
	assign reply_byte = loopback ? rx_din : tx_frame.bytes[7];
	// Tag marks the last byte of each reply
	assign reply_last = ~loopback & (tx_left == 4'd1);

	byte_fifo #(.dw(9), .aw(reply_aw)) reply_q (
		.clk   (clk),
		.rst   (rst),
		.din   ({reply_byte, reply_last}),
		.we    (reply_we),
		.dout  ({tx_dout, tx_done}),
		.re    (tx_take),
		.empty (reply_empty),
		.full  (reply_full)
	);

	assign tx_rdy  = ~reply_empty;
	assign tx_take = tx_rdy & tx_stb;

	// Replies queued or still on the way, to find the last one of a packet
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else if (xfer_last && !(tx_take && tx_done)) begin
			pending <= pending + 1'b1;
		end else if (!xfer_last && tx_take && tx_done) begin
			pending <= pending - 1'b1;
		end
	end

	assign tx_end = tx_rdy & tx_done & (pending == 'd1) & ~rx_active;

	// Next transaction never completes before the previous bus access returns
	a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
		xfer_last |-> !busy);
	// Host keeps draining so nonce and replies always find room
	a_reply_room: assert property (@(posedge clk) disable iff (rst)
		reply_we |-> !reply_full);

endmodule

/* source/lb_arbiter.sv */
`timescale 1ns/1ps

module lb_arbiter (
	input  logic     clk,
	input  logic     rst,
	lb_req_if.arb    a,
	lb_req_if.arb    b,
	lb_bus_if.master bus
);

	logic       gnt_a;
	logic       gnt_b;
	// Port b won the last grant
	logic       last_b;
	// One-hot owner of the access now on the bus, bit 1 for port b
	logic [1:0] owner;

	// Lone requester wins at once, otherwise alternate
	assign gnt_a = a.req & (~b.req | last_b);
	assign gnt_b = b.req & (~a.req | ~last_b);

	assign a.gnt = gnt_a;
	assign b.gnt = gnt_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			last_b <= 1'b0;
			owner  <= 2'b00;
		end else begin
			if (gnt_a) begin
				last_b <= 1'b0;
			end else if (gnt_b) begin
				last_b <= 1'b1;
			end
			owner <= {gnt_b, gnt_a};
		end
	end

	// Shared bus follows the granted port
	assign bus.strobe = gnt_a | gnt_b;
	assign bus.rd     = gnt_b ? b.rd : a.rd;
	assign bus.addr   = gnt_b ? b.addr : a.addr;
	assign bus.wdata  = gnt_b ? b.wdata : a.wdata;

	// Return goes only to the owner
	assign a.rvalid = owner[0];
	assign b.rvalid = owner[1];
	assign a.rdata  = owner[0] ? bus.rdata : '0;
	assign b.rdata  = owner[1] ? bus.rdata : '0;

	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		$onehot0({gnt_a, gnt_b}));
	// Waiting gateways keep their request on the bus unchanged
	a_hold_a: assert property (@(posedge clk) disable iff (rst)
		a.req && !gnt_a |=> a.req && $stable(a.addr) && $stable(a.wdata));
	a_hold_b: assert property (@(posedge clk) disable iff (rst)
		b.req && !gnt_b |=> b.req && $stable(b.addr) && $stable(b.wdata));

endmodule

/* source/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank
	import host_gate_pkg::*;
#(
	parameter int reg_aw = 4
) (
	input  logic   clk,
	input  logic   rst,
	lb_bus_if.bank bus
);

	localparam int n_regs = 2 ** reg_aw;

	logic [lb_data_w-1:0] regs [n_regs];
	logic [reg_aw-1:0]    idx;
	logic                 hit_scratch;
	logic                 hit_id;

	// Scratch registers sit at the bottom of the address map
	assign idx         = bus.addr[reg_aw-1:0];
	assign hit_scratch = (bus.addr[lb_addr_w-1:reg_aw] == '0);
	assign hit_id      = (bus.addr == id_addr);

	// Write takes effect in the strobe cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < n_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (bus.strobe && !bus.rd && hit_scratch) begin
			regs[idx] <= bus.wdata;
		end
	end

	// Contents after the access, so a write echoes its own data
	always_ff @(posedge clk) begin
		if (bus.strobe) begin
			if (hit_scratch) begin
				bus.rdata <= bus.rd ? regs[idx] : bus.wdata;
			end else if (hit_id) begin
				// Identity is read only, writes fall through
				bus.rdata <= gate_id;
			end else begin
				bus.rdata <= '0;
			end
		end
	end

endmodule

/* source/dual_gate_top.sv */
`timescale 1ns/1ps

module dual_gate_top #(
	parameter int reg_aw   = 4,
	parameter int reply_aw = 5
) (
	input  logic       clk,
	input  logic       rst,
	// Host a
	input  logic [7:0] a_rx_din,
	input  logic       a_rx_stb,
	input  logic       a_rx_end,
	output logic [7:0] a_tx_dout,
	output logic       a_tx_rdy,
	output logic       a_tx_end,
	input  logic       a_tx_stb,
	// Host b
	input  logic [7:0] b_rx_din,
	input  logic       b_rx_stb,
	input  logic       b_rx_end,
	output logic [7:0] b_tx_dout,
	output logic       b_tx_rdy,
	output logic       b_tx_end,
	input  logic       b_tx_stb
);

	lb_req_if req_a ();
	lb_req_if req_b ();
	lb_bus_if bus0 ();

	host_gate #(.reply_aw(reply_aw)) gate_a (
		.clk     (clk),
		.rst     (rst),
		.rx_din  (a_rx_din),
		.rx_stb  (a_rx_stb),
		.rx_end  (a_rx_end),
		.tx_dout (a_tx_dout),
		.tx_rdy  (a_tx_rdy),
		.tx_end  (a_tx_end),
		.tx_stb  (a_tx_stb),
		.lb      (req_a.master)
	);

	host_gate #(.reply_aw(reply_aw)) gate_b (
		.clk     (clk),
		.rst     (rst),
		.rx_din  (b_rx_din),
		.rx_stb  (b_rx_stb),
		.rx_end  (b_rx_end),
		.tx_dout (b_tx_dout),
		.tx_rdy  (b_tx_rdy),
		.tx_end  (b_tx_end),
		.tx_stb  (b_tx_stb),
		.lb      (req_b.master)
	);

	// Both gateways share one bank through the arbiter
	lb_arbiter arb0 (
		.clk (clk),
		.rst (rst),
		.a   (req_a.arb),
		.b   (req_b.arb),
		.bus (bus0.master)
	);

	reg_bank #(.reg_aw(reg_aw)) bank0 (
		.clk (clk),
		.rst (rst),
		.bus (bus0.bank)
	);

endmodule

/* include/gate_tb_util.svh */
`ifndef GATE_TB_UTIL_SVH
`define GATE_TB_UTIL_SVH

// Fibonacci LFSR state, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h9927;
int          n_checks   = 0;
int          n_errors   = 0;

// One step per bit taken, newest bit lands at the bottom
function automatic logic [31:0] lfsr_take(input int n);
	logic [31:0] val;
	logic        fb;
	val = '0;
	for (int i = 0; i < n; i++) begin
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		val        = {val[30:0], fb};
	end
	return val;
endfunction

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
	n_checks++;
	if (act !== exp) begin
		n_errors++;
		$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

task automatic check_frame(input string name, input lb_frame_u exp, input lb_frame_u act);
	n_checks++;
	if (act.bytes !== exp.bytes) begin
		n_errors++;
		$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp.bytes, act.bytes);
	end
endtask

// Single bit results such as tx_end and tx_rdy
task automatic check_flag(input string name, input logic exp, input logic act);
	n_checks++;
	if (act !== exp) begin
		n_errors++;
		$display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
	end
endtask

`endif

/* test/dual_gate_tb.sv */
`timescale 1ns/1ps

module dual_gate_tb
	import host_gate_pkg::*;
();

	`include "gate_tb_util.svh"

	localparam int reg_aw   = 4;
	localparam int reply_aw = 5;
	localparam int n_regs   = 2 ** reg_aw;
	// Six short tests, none near 600 cycles, so this leaves wide margin
	localparam int max_cycles = 4000;

	logic       clk = 1'b0;
	logic       rst;
	logic [7:0] a_rx_din;
	logic       a_rx_stb;
	logic       a_rx_end;
	logic [7:0] a_tx_dout;
	logic       a_tx_rdy;
	logic       a_tx_end;
	logic       a_tx_stb;
	logic [7:0] b_rx_din;
	logic       b_rx_stb;
	logic       b_rx_end;
	logic [7:0] b_tx_dout;
	logic       b_tx_rdy;
	logic       b_tx_end;
	logic       b_tx_stb;
	int         cycles = 0;
	// Expected register bank contents
	logic [lb_data_w-1:0] model_regs [n_regs];

	dual_gate_top #(.reg_aw(reg_aw), .reply_aw(reply_aw)) dut0 (
		.clk       (clk),
		.rst       (rst),
		.a_rx_din  (a_rx_din),
		.a_rx_stb  (a_rx_stb),
		.a_rx_end  (a_rx_end),
		.a_tx_dout (a_tx_dout),
		.a_tx_rdy  (a_tx_rdy),
		.a_tx_end  (a_tx_end),
		.a_tx_stb  (a_tx_stb),
		.b_rx_din  (b_rx_din),
		.b_rx_stb  (b_rx_stb),
		.b_rx_end  (b_rx_end),
		.b_tx_dout (b_tx_dout),
		.b_tx_rdy  (b_tx_rdy),
		.b_tx_end  (b_tx_end),
		.b_tx_stb  (b_tx_stb)
	);

	always #4 clk = ~clk;

	// Watchdog on total run length
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout after %0d cycles, replies stopped arriving", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic drive_rx(input bit port, input logic [7:0] din, input logic stb,
			input logic eop);
		if (port) begin
			b_rx_din = din;
			b_rx_stb = stb;
			b_rx_end = eop;
		end else begin
			a_rx_din = din;
			a_rx_stb = stb;
			a_rx_end = eop;
		end
	endtask

	task automatic set_tx_stb(input bit port, input logic stb);
		if (port) begin
			b_tx_stb = stb;
		end else begin
			a_tx_stb = stb;
		end
	endtask

	// Nonce then frames, first wire byte is bytes[7], end pulse after the last byte
	task automatic send_packet(input bit port, input lb_frame_u nonce, input lb_frame_u reqs[$]);
		lb_frame_u f;
		for (int i = 0; i <= reqs.size(); i++) begin
			if (i == 0) begin
				f = nonce;
			end else begin
				f = reqs[i - 1];
			end
			for (int j = 7; j >= 0; j--) begin
				@(negedge clk);
				drive_rx(port, f.bytes[j], 1'b1, 1'b0);
			end
		end
		@(negedge clk);
		drive_rx(port, 8'h00, 1'b0, 1'b1);
		@(negedge clk);
		drive_rx(port, 8'h00, 1'b0, 1'b0);
	endtask

	// Takes a byte at each rising edge where tx_rdy and tx_stb are both high
	task automatic collect_reply(input bit port, input int n_frames, output lb_frame_u got[$]);
		lb_frame_u cur;
		int        n_bytes;
		int        taken;
		logic      rdy;
		string     tag;
		n_bytes = 8 * n_frames;
		taken   = 0;
		tag     = port ? "b" : "a";
		got     = {};
		while (taken < n_bytes) begin
			@(negedge clk);
			set_tx_stb(port, 1'b1);
			rdy = port ? b_tx_rdy : a_tx_rdy;
			if (rdy) begin
				cur.bytes = {cur.bytes[6:0], port ? b_tx_dout : a_tx_dout};
				// End of packet only on the very last reply byte
				check_flag({tag, "_tx_end"}, taken == n_bytes - 1, port ? b_tx_end : a_tx_end);
				taken++;
				if (taken % 8 == 0) begin
					got.push_back(cur);
				end
			end
		end
		@(negedge clk);
		set_tx_stb(port, 1'b0);
		// Nothing left over after the packet
		check_flag({tag, "_tx_rdy after reply"}, 1'b0, port ? b_tx_rdy : a_tx_rdy);
	endtask

	// Scratch below n_regs, identity read only, everything else reads zero
	function automatic logic [lb_data_w-1:0] model_access(input lb_frame_u req);
		lb_ctl_t ctl;
		ctl = req.fields.ctl;
		if (ctl.addr < n_regs) begin
			if (!ctl.rd) begin
				model_regs[ctl.addr[reg_aw-1:0]] = req.fields.data;
			end
			return model_regs[ctl.addr[reg_aw-1:0]];
		end else if (ctl.addr == id_addr) begin
			return gate_id;
		end
		return '0;
	endfunction

	function automatic lb_frame_u make_frame(input logic rd, input logic [lb_addr_w-1:0] addr,
			input logic [lb_data_w-1:0] data);
		lb_frame_u f;
		f.fields.ctl      = '0;
		f.fields.ctl.rd   = rd;
		f.fields.ctl.addr = addr;
		f.fields.data     = data;
		return f;
	endfunction

	function automatic lb_frame_u next_nonce();
		lb_frame_u f;
		f.fields.ctl  = lfsr_take(32);
		f.fields.data = lfsr_take(32);
		return f;
	endfunction

	// Random access inside eight scratch registers from base
	function automatic lb_frame_u rand_frame(input int base);
		logic [31:0] rd;
		logic [31:0] idx;
		logic [31:0] data;
		rd   = lfsr_take(1);
		idx  = lfsr_take(3);
		data = lfsr_take(32);
		return make_frame(rd[0], 24'(base) + idx[23:0], data);
	endfunction

	// One packet on one port, checked against the model in request order
	task automatic run_packet(input bit port, input lb_frame_u nonce, input lb_frame_u reqs[$],
			input bit hold);
		lb_frame_u want[$];
		lb_frame_u got[$];
		lb_frame_u r;
		string     tag;
		tag = port ? "b" : "a";
		foreach (reqs[i]) begin
			r.fields.ctl  = reqs[i].fields.ctl;
			r.fields.data = model_access(reqs[i]);
			want.push_back(r);
		end
		if (hold) begin
			// tx_stb stays low while the packet arrives
			send_packet(port, nonce, reqs);
			// Every reply is queued within 11 cycles of the last byte
			repeat (12) @(negedge clk);
			check_flag({tag, "_tx_rdy while held"}, 1'b1, port ? b_tx_rdy : a_tx_rdy);
			// Head still holds the first nonce byte
			check_byte({tag, "_tx_dout while held"}, nonce.bytes[7],
				port ? b_tx_dout : a_tx_dout);
			collect_reply(port, reqs.size() + 1, got);
		end else begin
			fork
				send_packet(port, nonce, reqs);
				collect_reply(port, reqs.size() + 1, got);
			join
		end
		for (int j = 7; j >= 0; j--) begin
			check_byte($sformatf("%s nonce byte %0d", tag, 7 - j), nonce.bytes[j], got[0].bytes[j]);
		end
		foreach (want[i]) begin
			check_frame($sformatf("%s reply %0d", tag, i), want[i], got[i + 1]);
		end
	endtask

	task automatic test_loopback();
		lb_frame_u q[$];
		lb_frame_u f;
		// Reserved bits set to show the whole control word comes back
		f = make_frame(1'b1, 24'h000003, 32'h0);
		f.fields.ctl.rsv_hi = 3'b101;
		f.fields.ctl.rsv_lo = 4'ha;
		q.push_back(f);
		run_packet(1'b0, next_nonce(), q, 1'b0);
	endtask

	task automatic test_write_read();
		lb_frame_u q[$];
		q.push_back(make_frame(1'b0, 24'h000005, lfsr_take(32)));
		run_packet(1'b0, next_nonce(), q, 1'b0);
		q = {};
		q.push_back(make_frame(1'b1, 24'h000005, 32'h0));
		run_packet(1'b0, next_nonce(), q, 1'b0);
	endtask

	task automatic test_shared_bus();
		lb_frame_u q[$];
		q.push_back(make_frame(1'b0, 24'h000009, lfsr_take(32)));
		run_packet(1'b1, next_nonce(), q, 1'b0);
		q = {};
		q.push_back(make_frame(1'b1, 24'h000009, 32'h0));
		run_packet(1'b0, next_nonce(), q, 1'b0);
	endtask

	task automatic test_contention();
		lb_frame_u qa[$];
		lb_frame_u qb[$];
		lb_frame_u na;
		lb_frame_u nb;
		// Port a keeps to registers 0 to 7, port b to 8 to 15
		for (int i = 0; i < 6; i++) begin
			qa.push_back(rand_frame(0));
			qb.push_back(rand_frame(8));
		end
		na = next_nonce();
		nb = next_nonce();
		fork
			run_packet(1'b0, na, qa, 1'b0);
			run_packet(1'b1, nb, qb, 1'b0);
		join
	endtask

	task automatic test_decode();
		lb_frame_u q[$];
		q.push_back(make_frame(1'b1, id_addr, 32'h0));
		q.push_back(make_frame(1'b0, id_addr, 32'hdead_beef));
		q.push_back(make_frame(1'b1, id_addr, 32'h0));
		q.push_back(make_frame(1'b0, 24'h000040, 32'h1234_5678));
		q.push_back(make_frame(1'b1, 24'h000040, 32'h0));
		q.push_back(make_frame(1'b1, 24'h800000, 32'h0));
		run_packet(1'b0, next_nonce(), q, 1'b0);
	endtask

	task automatic test_backpressure();
		lb_frame_u q[$];
		// Nonce plus three replies fill the 32 byte queue exactly
		q.push_back(make_frame(1'b0, 24'h000002, lfsr_take(32)));
		q.push_back(make_frame(1'b1, 24'h000002, 32'h0));
		q.push_back(make_frame(1'b1, 24'h000009, 32'h0));
		run_packet(1'b0, next_nonce(), q, 1'b1);
	endtask

	initial begin
		rst      = 1'b1;
		a_rx_din = 8'h00;
		a_rx_stb = 1'b0;
		a_rx_end = 1'b0;
		a_tx_stb = 1'b0;
		b_rx_din = 8'h00;
		b_rx_stb = 1'b0;
		b_rx_end = 1'b0;
		b_tx_stb = 1'b0;
		foreach (model_regs[i]) begin
			model_regs[i] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// Quiet outputs out of reset
		check_flag("a_tx_rdy after reset", 1'b0, a_tx_rdy);
		check_flag("b_tx_rdy after reset", 1'b0, b_tx_rdy);
		check_flag("a_tx_end after reset", 1'b0, a_tx_end);
		check_flag("b_tx_end after reset", 1'b0, b_tx_end);
		test_loopback();
		test_write_read();
		test_shared_bus();
		test_contention();
		test_decode();
		test_backpressure();
		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* dual_gate_top.f */
+incdir+include
source/host_gate_pkg.sv
source/lb_if.sv
source/byte_fifo.sv
source/host_gate.sv
source/lb_arbiter.sv
source/reg_bank.sv
source/dual_gate_top.sv
test/dual_gate_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f dual_gate_top.f --top-module dual_gate_tb -o sim_dual_gate

out=$(./obj_dir/sim_dual_gate 2>&1) || true
echo "$out"

echo "$out" | grep -qx 'All tests passed!'
